/* hdl/ring_settings.svh */
`ifndef RING_SETTINGS_SVH
`define RING_SETTINGS_SVH

// array size
`define RING_N_STAGE 4

// datapath and host bus widths
`define RING_DATA_W  32
`define RING_ADDR_W  16
`define RING_COUNT_W 16
`define RING_OP_W    3

// region field in the top address bits
`define RING_REGION_LSB   14
`define RING_REGION_W     2
`define RING_REGION_STAGE 2'd0
`define RING_REGION_RUN   2'd1
`define RING_REGION_CLEAR 2'd2

// stage index field
`define RING_STAGE_LSB 4
`define RING_STAGE_W   2

// register index field, low address bits
`define RING_REG_LSB   0
`define RING_REG_W     2
`define RING_REG_OP    2'd0
`define RING_REG_CONST 2'd1
`define RING_REG_OUT   2'd2
`define RING_REG_COUNT 2'd3

`endif

/* hdl/ring_pkg.sv */
`default_nettype none

`include "ring_settings.svh"

package ring_pkg;

   // host bus words
   typedef logic [`RING_DATA_W-1:0] data_t;
   typedef logic [`RING_ADDR_W-1:0] addr_t;

   // address fields
   typedef logic [`RING_REGION_W-1:0] region_t;
   typedef logic [`RING_STAGE_W-1:0]  stage_idx_t;
   typedef logic [`RING_REG_W-1:0]    reg_sel_t;

   // remaining steps of a run
   typedef logic [`RING_COUNT_W-1:0] count_t;

   // stage operations, applied to ring input and constant
   typedef enum logic [`RING_OP_W-1:0] {
      op_pass = 3'd0,
      op_add  = 3'd1,
      op_sub  = 3'd2,
      op_and  = 3'd3,
      op_xor  = 3'd4,
      op_mul  = 3'd5
   } stage_op_e;

endpackage

`default_nettype wire

/* hdl/stage_ctrl_if.sv */
`default_nettype none

`include "ring_settings.svh"

interface stage_ctrl_if;
   import ring_pkg::*;

   // per-stage write strobes, one hot
   logic [`RING_N_STAGE-1:0] sel;
   reg_sel_t                 reg_sel;
   data_t                    wdata;

   // run start, broadcast to every stage
   logic   run_start;
   count_t run_count;

   // global configuration clear
   logic clear;

   modport host (
      output sel,
      output reg_sel,
      output wdata,
      output run_start,
      output run_count,
      output clear
   );

   modport stage (
      input sel,
      input reg_sel,
      input wdata,
      input run_start,
      input run_count,
      input clear
   );

endinterface

`default_nettype wire

/* hdl/host_decode.sv */
`default_nettype none

`include "ring_settings.svh"

module host_decode (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  valid,
   input  wire ring_pkg::addr_t addr,
   input  wire                  we,
   input  wire ring_pkg::data_t wdata,
   output logic                 ready,
   stage_ctrl_if.host           ctrl
);
   import ring_pkg::*;

   region_t    region;
   stage_idx_t stage_idx;
   reg_sel_t   reg_idx;
   logic       stage_wr;

   // address fields
   assign region    = addr[`RING_REGION_LSB +: `RING_REGION_W];
   assign stage_idx = addr[`RING_STAGE_LSB +: `RING_STAGE_W];
   assign reg_idx   = addr[`RING_REG_LSB +: `RING_REG_W];

   assign stage_wr = valid && we && (region == `RING_REGION_STAGE);

   // one-hot select of the addressed stage
   always_comb begin
      for (int i = 0; i < `RING_N_STAGE; i++) begin
         ctrl.sel[i] = stage_wr && (stage_idx == stage_idx_t'(i));
      end
   end

   // write payload goes to every stage, sel picks the target
   always_comb begin
      ctrl.reg_sel = reg_idx;
      ctrl.wdata   = wdata;
   end

   // run write loads all step counters
   always_comb begin
      ctrl.run_start = valid && we && (region == `RING_REGION_RUN);
      ctrl.run_count = wdata[`RING_COUNT_W-1:0];
   end

   // reads in the clear region clear as well
   always_comb begin
      ctrl.clear = valid && (region == `RING_REGION_CLEAR);
   end

   // one cycle access latency, no back-pressure
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready <= 1'b0;
      end else begin
         ready <= valid;
      end
   end

endmodule

`default_nettype wire

/* hdl/ring_stage.sv */
`default_nettype none

`include "ring_settings.svh"

module ring_stage #(
   parameter int STAGE_IDX = 0
) (
   input  wire                     clk,
   input  wire                     rst,
   stage_ctrl_if.stage             ctrl,
   input  wire ring_pkg::reg_sel_t reg_sel,
   input  wire ring_pkg::data_t    flow_in,
   output ring_pkg::data_t         flow_out,
   output ring_pkg::data_t         stage_rdata,
   output logic                    done
);
   import ring_pkg::*;

   stage_op_e op_q;
   data_t     const_q;
   data_t     out_q;
   count_t    count_q;
   data_t     step_val;
   logic      wr_en;
   logic      stepping;

   assign wr_en    = ctrl.sel[STAGE_IDX];
   assign stepping = (count_q != '0);

   // op and constant
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op_q    <= op_pass;
         const_q <= '0;
      end else if (ctrl.clear) begin
         op_q    <= op_pass;
         const_q <= '0;
      end else if (wr_en) begin
         case (ctrl.reg_sel)
            `RING_REG_OP:    op_q    <= stage_op_e'(ctrl.wdata[`RING_OP_W-1:0]);
            `RING_REG_CONST: const_q <= ctrl.wdata;
            default: ;
         endcase
      end
   end

   // output register, a step wins over a host seed
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_q <= '0;
      end else if (ctrl.clear) begin
         out_q <= '0;
      end else if (stepping) begin
         out_q <= step_val;
      end else if (wr_en && (ctrl.reg_sel == `RING_REG_OUT)) begin
         out_q <= ctrl.wdata;
      end
   end

   // step counter
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count_q <= '0;
      end else if (ctrl.clear) begin
         count_q <= '0;
      end else if (ctrl.run_start) begin
         count_q <= ctrl.run_count;
      end else if (stepping) begin
         count_q <= count_q - 1'b1;
      end
   end

   // operation on ring input and constant
   always_comb begin
      case (op_q)
         op_pass: step_val = flow_in;
         op_add:  step_val = flow_in + const_q;
         op_sub:  step_val = flow_in - const_q;
         op_and:  step_val = flow_in & const_q;
         op_xor:  step_val = flow_in ^ const_q;
         // low word only
         op_mul:  step_val = flow_in * const_q;
         default: step_val = flow_in;
      endcase
   end

   // register readback at the host address
   always_comb begin
      case (reg_sel)
         `RING_REG_OP:    stage_rdata = {{(`RING_DATA_W-`RING_OP_W){1'b0}}, op_q};
         `RING_REG_CONST: stage_rdata = const_q;
         `RING_REG_OUT:   stage_rdata = out_q;
         default:         stage_rdata = {{(`RING_DATA_W-`RING_COUNT_W){1'b0}}, count_q};
      endcase
   end

   // neighbours see the registered value, so all stages step together
   assign flow_out = out_q;
   assign done     = ~stepping;

endmodule

`default_nettype wire

/* hdl/result_collect.sv */
`default_nettype none

`include "ring_settings.svh"

module result_collect (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  valid,
   input  wire ring_pkg::addr_t addr,
   input  wire ring_pkg::data_t stage_rdata [`RING_N_STAGE],
   input  wire [`RING_N_STAGE-1:0] done,
   output ring_pkg::data_t      rdata
);
   import ring_pkg::*;

   region_t    region;
   stage_idx_t stage_idx;
   logic       all_done;
   data_t      rd_next;

   assign region    = addr[`RING_REGION_LSB +: `RING_REGION_W];
   assign stage_idx = addr[`RING_STAGE_LSB +: `RING_STAGE_W];

   // run is done only when every counter reached zero
   assign all_done = &done;

   always_comb begin
      case (region)
         `RING_REGION_STAGE: rd_next = stage_rdata[stage_idx];
         `RING_REGION_RUN:   rd_next = {{(`RING_DATA_W-1){1'b0}}, all_done};
         default:            rd_next = '0;
      endcase
   end

   // captured with the access, lines up with ready
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rdata <= '0;
      end else if (valid) begin
         rdata <= rd_next;
      end
   end

endmodule

`default_nettype wire

/* hdl/ring_array.sv */
`default_nettype none

`include "ring_settings.svh"

module ring_array (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  valid,
   input  wire ring_pkg::addr_t addr,
   input  wire                  we,
   input  wire ring_pkg::data_t wdata,
   output logic                 ready,
   output ring_pkg::data_t      rdata
);
   import ring_pkg::*;

   // ring links, link i is the output of stage i
   wire data_t              ring_link [`RING_N_STAGE];
   wire data_t              stage_rdata [`RING_N_STAGE];
   wire [`RING_N_STAGE-1:0] stage_done;
   wire reg_sel_t           rd_reg_sel;

   // read index for the stage readback muxes
   assign rd_reg_sel = addr[`RING_REG_LSB +: `RING_REG_W];

   stage_ctrl_if u_ctrl ();

   host_decode u_decode (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .addr  (addr),
      .we    (we),
      .wdata (wdata),
      .ready (ready),
      .ctrl  (u_ctrl.host)
   );

   for (genvar i = 0; i < `RING_N_STAGE; i++) begin : g_stage
      // stage 0 takes the last stage, which closes the ring
      localparam int PREV = (i == 0) ? `RING_N_STAGE - 1 : i - 1;

      ring_stage #(
         .STAGE_IDX (i)
      ) u_stage (
         .clk         (clk),
         .rst         (rst),
         .ctrl        (u_ctrl.stage),
         .reg_sel     (rd_reg_sel),
         .flow_in     (ring_link[PREV]),
         .flow_out    (ring_link[i]),
         .stage_rdata (stage_rdata[i]),
         .done        (stage_done[i])
      );
   end

   result_collect u_collect (
      .clk         (clk),
      .rst         (rst),
      .valid       (valid),
      .addr        (addr),
      .stage_rdata (stage_rdata),
      .done        (stage_done),
      .rdata       (rdata)
   );

endmodule

`default_nettype wire

/* bench/ring_array_tb.sv */
`default_nettype none

`include "ring_settings.svh"

module ring_array_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import ring_pkg::*;

   localparam int CLK_PERIOD = 4;
   localparam int N = `RING_N_STAGE;
   localparam int READY_LIMIT = 8;
   localparam int POLL_LIMIT = 40;
   // budget of about 50 host accesses per test, 3 cycles each
   localparam int N_TESTS = 6;
   localparam int ACCESSES_PER_TEST = 50;
   localparam int CYCLES_PER_ACCESS = 3;
   localparam int MARGIN = 4;
   localparam int WATCHDOG_NS =
      N_TESTS * ACCESSES_PER_TEST * CYCLES_PER_ACCESS * MARGIN * CLK_PERIOD;

   logic  clk = 1'b0;
   logic  rst;
   logic  valid;
   addr_t addr;
   logic  we;
   data_t wdata;
   logic  ready;
   data_t rdata;

   // reference copy of every stage
   stage_op_e m_op [N];
   data_t     m_const [N];
   data_t     m_out [N];

   // pending read checks, consumed by the compare process
   data_t got_q [$];
   data_t lo_q [$];
   data_t hi_q [$];
   string tag_q [$];

   logic [31:0] lfsr_state = 32'hd8d5_9283;
   int err_count = 0;
   int check_count = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int test_err_start = 0;

   ring_array u_dut (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .addr  (addr),
      .we    (we),
      .wdata (wdata),
      .ready (ready),
      .rdata (rdata)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic data_t draw(input int nbits);
      data_t v;
      v = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
         v = {v[`RING_DATA_W-2:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic addr_t stage_addr(input int s, input reg_sel_t r);
      addr_t a;
      a = '0;
      a[`RING_REGION_LSB +: `RING_REGION_W] = `RING_REGION_STAGE;
      a[`RING_STAGE_LSB +: `RING_STAGE_W] = s[`RING_STAGE_W-1:0];
      a[`RING_REG_LSB +: `RING_REG_W] = r;
      return a;
   endfunction

   function automatic addr_t region_addr(input region_t r);
      addr_t a;
      a = '0;
      a[`RING_REGION_LSB +: `RING_REGION_W] = r;
      return a;
   endfunction

   // one stage step, straight from the operation table
   function automatic data_t stage_ref(input stage_op_e op, input data_t din, input data_t c);
      case (op)
         op_add:  return din + c;
         op_sub:  return din - c;
         op_and:  return din & c;
         op_xor:  return din ^ c;
         op_mul:  return din * c;
         default: return din;
      endcase
   endfunction

   // all stages step at once from the previous outputs
   function automatic void model_steps(input int n);
      data_t prev [N];
      for (int k = 0; k < n; k++) begin
         prev = m_out;
         for (int s = 0; s < N; s++) begin
            m_out[s] = stage_ref(m_op[s], prev[(s + N - 1) % N], m_const[s]);
         end
      end
   endfunction

   function automatic void reset_model();
      for (int s = 0; s < N; s++) begin
         m_op[s] = op_pass;
         m_const[s] = '0;
         m_out[s] = '0;
      end
   endfunction

   task automatic bus_access(input addr_t a, input logic w, input data_t d, output data_t rd);
      int waited;
      @(posedge clk);
      // ready only pulses after an access
      assert (!ready) else begin
         $display("FAIL %0t: ready high with no access pending", $time);
         err_count++;
      end
      valid <= 1'b1;
      addr  <= a;
      we    <= w;
      wdata <= d;
      @(posedge clk);
      valid <= 1'b0;
      we    <= 1'b0;
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
      end while (!ready && waited < READY_LIMIT);
      if (!ready) begin
         $display("ready never came back for the access to address %h", a);
         err_count++;
      end
      rd = rdata;
   endtask

   task automatic bus_write(input addr_t a, input data_t d);
      data_t unused;
      bus_access(a, 1'b1, d, unused);
   endtask

   task automatic bus_read(input addr_t a, output data_t rd);
      bus_access(a, 1'b0, '0, rd);
   endtask

   task automatic check_read(input addr_t a, input data_t lo, input data_t hi, input string tag);
      data_t rd;
      bus_read(a, rd);
      got_q.push_back(rd);
      lo_q.push_back(lo);
      hi_q.push_back(hi);
      tag_q.push_back(tag);
   endtask

   // readback of all four registers against the model, count expected 0
   task automatic check_all_regs(input string tag);
      for (int s = 0; s < N; s++) begin
         check_read(stage_addr(s, `RING_REG_OP), data_t'(m_op[s]), data_t'(m_op[s]),
                    $sformatf("%s op%0d", tag, s));
         check_read(stage_addr(s, `RING_REG_CONST), m_const[s], m_const[s],
                    $sformatf("%s const%0d", tag, s));
         check_read(stage_addr(s, `RING_REG_OUT), m_out[s], m_out[s],
                    $sformatf("%s out%0d", tag, s));
         check_read(stage_addr(s, `RING_REG_COUNT), '0, '0, $sformatf("%s count%0d", tag, s));
      end
   endtask

   task automatic configure_random();
      for (int s = 0; s < N; s++) begin
         m_op[s] = stage_op_e'(draw(3) % 6);
         m_const[s] = draw(32);
         m_out[s] = draw(32);
         bus_write(stage_addr(s, `RING_REG_OP), data_t'(m_op[s]));
         bus_write(stage_addr(s, `RING_REG_CONST), m_const[s]);
         bus_write(stage_addr(s, `RING_REG_OUT), m_out[s]);
      end
   endtask

   task automatic wait_run_done();
      data_t rd;
      int polls;
      rd = '0;
      polls = 0;
      while (!rd[0] && polls < POLL_LIMIT) begin
         bus_read(region_addr(`RING_REGION_RUN), rd);
         polls++;
      end
      if (!rd[0]) begin
         $display("run still busy after %0d polls of the done bit", polls);
         err_count++;
      end
   endtask

   task automatic end_test(input string name);
      // two edges so the compare process has drained the queue
      repeat (2) @(posedge clk);
      tests_run++;
      if (err_count == test_err_start) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, err_count - test_err_start);
      end
      test_err_start = err_count;
   endtask

   // compare process
   always @(negedge clk) begin : compare
      data_t got;
      data_t lo;
      data_t hi;
      string tag;
      while (got_q.size() > 0) begin
         got = got_q.pop_front();
         lo = lo_q.pop_front();
         hi = hi_q.pop_front();
         tag = tag_q.pop_front();
         check_count++;
         assert (got >= lo && got <= hi) else begin
            err_count++;
            if (lo == hi)
               $display("FAIL %0t: %s read %h, expected %h", $time, tag, got, lo);
            else
               $display("FAIL %0t: %s read %h, expected %h to %h", $time, tag, got, lo, hi);
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("Regression failed");
      $finish;
   end

   initial begin : stimulus
      int n;
      int s;
      rst   = 1'b1;
      valid = 1'b0;
      addr  = '0;
      we    = 1'b0;
      wdata = '0;
      reset_model();
      repeat (2) @(posedge clk);
      rst <= 1'b0;

      check_all_regs("reset");
      check_read(region_addr(`RING_REGION_RUN), 1, 1, "reset done");
      end_test("reset values");

      configure_random();
      for (int i = 0; i < N; i++) begin
         bus_write(stage_addr(i, `RING_REG_COUNT), draw(16));
      end
      check_all_regs("readback");
      end_test("config readback");

      configure_random();
      n = int'(draw(5) % 20) + 1;
      bus_write(region_addr(`RING_REGION_RUN), data_t'(n));
      wait_run_done();
      model_steps(n);
      check_all_regs("short run");
      end_test("short run");

      // long run is still busy on the very next access
      n = 20 + int'(draw(4));
      bus_write(region_addr(`RING_REGION_RUN), data_t'(n));
      check_read(region_addr(`RING_REGION_RUN), 0, 0, "busy after run");
      wait_run_done();
      model_steps(n);
      check_all_regs("long run");
      bus_write(region_addr(`RING_REGION_RUN), '0);
      check_read(region_addr(`RING_REGION_RUN), 1, 1, "zero run done");
      check_all_regs("zero run");
      end_test("busy and zero run");

      configure_random();
      n = 20 + int'(draw(4));
      s = int'(draw(2));
      bus_write(region_addr(`RING_REGION_RUN), data_t'(n));
      check_read(stage_addr(s, `RING_REG_COUNT), 1, data_t'(n), "count in flight");
      wait_run_done();
      model_steps(n);
      check_all_regs("after count read");
      end_test("count in flight");

      configure_random();
      bus_write(region_addr(`RING_REGION_CLEAR), '0);
      reset_model();
      check_all_regs("clear");
      n = int'(draw(5) % 20) + 1;
      bus_write(region_addr(`RING_REGION_RUN), data_t'(n));
      wait_run_done();
      model_steps(n);
      check_all_regs("run after clear");
      end_test("global clear");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_count, err_count);
      if (err_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/ring_pkg.sv
hdl/stage_ctrl_if.sv
hdl/host_decode.sv
hdl/ring_stage.sv
hdl/result_collect.sv
hdl/ring_array.sv
bench/ring_array_tb.sv

/* Bender.yml */
package:
  name: ring_array

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ring_pkg.sv
      - hdl/stage_ctrl_if.sv
      - hdl/host_decode.sv
      - hdl/ring_stage.sv
      - hdl/result_collect.sv
      - hdl/ring_array.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/ring_array_tb.sv
